// ==== source/soc_pkg.sv ====
////////////////////////////////////////////////////////////
// shared definitions for the peripheral fabric
// memory map, bus request/response structs, device select
// and timing constants used by the decoder, the devices,
// the response stage and the testbench
////////////////////////////////////////////////////////////
package soc_pkg;

  ////////////////////////////////////////////////////////////
  // memory map
  localparam int          RAM_WORDS     = 256;
  localparam int          RAM_AW        = $clog2(RAM_WORDS);
  localparam logic [31:0] RAM_BASE      = 32'h0000_0000;
  localparam logic [31:0] RAM_END       = RAM_BASE + RAM_WORDS * 4;

  localparam logic [31:0] UART_TX_ADDR  = 32'h1000_0000;
  localparam logic [31:0] UART_LSR_ADDR = 32'h1000_0005;

  // clint style timer block, four word registers
  localparam logic [31:0] TIMER_BASE     = 32'h1100_0000;
  localparam logic [3:0]  TIMER_MTIME_LO = 4'h0;
  localparam logic [3:0]  TIMER_MTIME_HI = 4'h4;
  localparam logic [3:0]  TIMER_CMP_LO   = 4'h8;
  localparam logic [3:0]  TIMER_CMP_HI   = 4'hc;

  localparam logic [31:0] FREQ_ADDR     = 32'h1100_8000;

  localparam logic [31:0] IO_START      = 32'h1000_0000;
  localparam logic [31:0] IO_END        = 32'h1200_0000;

  ////////////////////////////////////////////////////////////
  // timing
  localparam logic [31:0] SYSTEM_CLK = 32'd10_000_000;

  // short bit time keeps simulation fast
  localparam int BAUD_DIV = 8;
  localparam int BAUD_CW  = $clog2(BAUD_DIV);

  // transmitter empty flag inside the status byte
  localparam int LSR_TX_EMPTY_BIT = 5;

  ////////////////////////////////////////////////////////////
  // bus types
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } bus_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } bus_rsp_t;

  typedef struct packed {
    logic ram;
    logic uart_data;
    logic uart_status;
    logic timer;
    logic freq;
    logic none;
  } dev_sel_t;

endpackage

// ==== source/bus_decode.sv ====
////////////////////////////////////////////////////////////
// address decoder for the peripheral bus
// turns a held request into a one-hot device select
// selects drop while the response is being returned
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module bus_decode (
  input  logic              clk,
  input  logic              resetn,
  input  logic              valid,
  input  soc_pkg::bus_req_t req,
  input  logic              pending,
  output soc_pkg::dev_sel_t sel
);
  import soc_pkg::*;

  logic active;
  logic is_ram;
  logic is_io;
  logic is_uart_data;
  logic is_uart_status;
  logic is_timer;
  logic is_freq;
  logic known_io;

  // one request in flight, blocked during the ready cycle
  assign active = valid && !pending;

  assign is_ram = (req.addr >= RAM_BASE) && (req.addr < RAM_END);
  assign is_io  = (req.addr >= IO_START) && (req.addr < IO_END);

  assign is_uart_data   = (req.addr == UART_TX_ADDR);
  assign is_uart_status = (req.addr == UART_LSR_ADDR);
  // word aligned registers inside the 16 byte timer window
  assign is_timer = (req.addr[31:4] == TIMER_BASE[31:4]) && (req.addr[1:0] == 2'b00);
  assign is_freq  = (req.addr == FREQ_ADDR);

  assign known_io = is_uart_data || is_uart_status || is_timer || is_freq;

  always_comb begin
    sel = '0;
    if (active) begin
      sel.ram         = is_ram;
      sel.uart_data   = is_io && is_uart_data;
      sel.uart_status = is_io && is_uart_status;
      sel.timer       = is_io && is_timer;
      sel.freq        = is_io && is_freq;
      // unknown io register or a hole in the map
      sel.none        = !is_ram && (!is_io || !known_io);
    end
  end

  // the master holds its request until the ready pulse
  req_held_a : assert property (@(posedge clk) disable iff (!resetn)
    (valid && !pending) |=> (valid && $stable(req)));

endmodule

// ==== source/block_ram.sv ====
////////////////////////////////////////////////////////////
// word organised block ram with byte write strobes
// read data is captured on the select edge and shown
// together with the one cycle ready pulse
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module block_ram (
  input  logic              clk,
  input  logic              resetn,
  input  logic              sel,
  input  soc_pkg::bus_req_t req,
  output logic [31:0]       rdata,
  output logic              ready
);
  import soc_pkg::*;

  logic [31:0]       mem [RAM_WORDS];
  logic [31:0]       rdata_q;
  logic [RAM_AW-1:0] word_addr;

  assign word_addr = req.addr[RAM_AW+1:2];

  // storage and read register
  always_ff @(posedge clk) begin
    if (sel) begin
      rdata_q <= mem[word_addr];
      for (int b = 0; b < 4; b++) begin
        if (req.wstrb[b]) begin
          mem[word_addr][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready <= 1'b0;
    end else begin
      ready <= sel;
    end
  end

  assign rdata = ready ? rdata_q : 32'h0;

endmodule

// ==== source/uart_tx.sv ====
////////////////////////////////////////////////////////////
// uart transmitter, 8n1, no back pressure
// a data write starts a frame only when the line is idle
// status read returns the transmitter empty flag
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module uart_tx (
  input  logic              clk,
  input  logic              resetn,
  input  logic              sel_data,
  input  logic              sel_status,
  input  soc_pkg::bus_req_t req,
  output logic [31:0]       rdata,
  output logic              ready,
  output logic              txd
);
  import soc_pkg::*;

  logic               busy;
  logic [9:0]         shift;
  logic [BAUD_CW-1:0] baud_cnt;
  logic [3:0]         bit_cnt;
  logic               start;
  logic               status_q;
  logic [7:0]         lsr;

  // writes while busy are dropped
  assign start = sel_data && (|req.wstrb) && !busy;

  ////////////////////////////////////////////////////////////
  // frame shifter, stop bit refills with ones
  always_ff @(posedge clk) begin
    if (!resetn) begin
      busy     <= 1'b0;
      shift    <= '1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (!busy) begin
      if (start) begin
        busy     <= 1'b1;
        shift    <= {1'b1, req.wdata[7:0], 1'b0};
        baud_cnt <= '0;
        bit_cnt  <= '0;
      end
    end else if (baud_cnt == BAUD_CW'(BAUD_DIV - 1)) begin
      baud_cnt <= '0;
      shift    <= {1'b1, shift[9:1]};
      if (bit_cnt == 4'd9) begin
        busy <= 1'b0;
      end else begin
        bit_cnt <= bit_cnt + 4'd1;
      end
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  assign txd = shift[0];

  ////////////////////////////////////////////////////////////
  // bus side
  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready    <= 1'b0;
      status_q <= 1'b0;
    end else begin
      ready    <= sel_data || sel_status;
      status_q <= sel_status;
    end
  end

  always_comb begin
    lsr                   = 8'h00;
    lsr[LSR_TX_EMPTY_BIT] = !busy;
  end

  // data register reads back as zero
  assign rdata = (ready && status_q) ? {16'h0, lsr, 8'h00} : 32'h0;

  idle_line_a : assert property (@(posedge clk) disable iff (!resetn)
    !busy |-> txd);

endmodule

// ==== source/machine_timer.sv ====
////////////////////////////////////////////////////////////
// machine timer, mtime and mtimecmp as 64 bit registers
// mtime counts every clock, mtimecmp is written per word
// irq is high while mtime has reached mtimecmp
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module machine_timer (
  input  logic              clk,
  input  logic              resetn,
  input  logic              sel,
  input  soc_pkg::bus_req_t req,
  output logic [31:0]       rdata,
  output logic              ready,
  output logic              irq
);
  import soc_pkg::*;

  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic [31:0] rdata_q;
  logic [31:0] rd_word;
  logic        wr;

  assign wr = sel && (|req.wstrb);

  ////////////////////////////////////////////////////////////
  // counter and compare
  always_ff @(posedge clk) begin
    if (!resetn) begin
      mtime    <= '0;
      // all ones keeps the interrupt quiet out of reset
      mtimecmp <= '1;
      irq      <= 1'b0;
    end else begin
      mtime <= mtime + 64'd1;
      if (wr && req.addr[3:0] == TIMER_CMP_LO) begin
        mtimecmp[31:0] <= req.wdata;
      end
      if (wr && req.addr[3:0] == TIMER_CMP_HI) begin
        mtimecmp[63:32] <= req.wdata;
      end
      irq <= (mtime >= mtimecmp);
    end
  end

  always_comb begin
    case (req.addr[3:0])
      TIMER_MTIME_LO: rd_word = mtime[31:0];
      TIMER_MTIME_HI: rd_word = mtime[63:32];
      TIMER_CMP_LO:   rd_word = mtimecmp[31:0];
      TIMER_CMP_HI:   rd_word = mtimecmp[63:32];
      default:        rd_word = 32'h0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // bus side
  always_ff @(posedge clk) begin
    if (sel) begin
      rdata_q <= rd_word;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready <= 1'b0;
    end else begin
      ready <= sel;
    end
  end

  assign rdata = ready ? rdata_q : 32'h0;

endmodule

// ==== source/resp_mux.sv ====
////////////////////////////////////////////////////////////
// response stage, merges device ready pulses and data
// answers the frequency word and unmapped accesses itself
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module resp_mux (
  input  logic              clk,
  input  logic              resetn,
  input  soc_pkg::dev_sel_t sel,
  input  logic [31:0]       ram_rdata,
  input  logic [31:0]       uart_rdata,
  input  logic [31:0]       timer_rdata,
  input  logic              ram_ready,
  input  logic              uart_ready,
  input  logic              timer_ready,
  output soc_pkg::bus_rsp_t rsp,
  output logic              access_fault
);
  import soc_pkg::*;

  logic freq_ready;
  logic none_ready;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      freq_ready <= 1'b0;
      none_ready <= 1'b0;
    end else begin
      freq_ready <= sel.freq;
      none_ready <= sel.none;
    end
  end

  assign rsp.ready = ram_ready || uart_ready || timer_ready || freq_ready || none_ready;

  // fault read falls through to zero
  assign rsp.rdata = ram_ready   ? ram_rdata   :
                     uart_ready  ? uart_rdata  :
                     timer_ready ? timer_rdata :
                     freq_ready  ? SYSTEM_CLK  :
                     32'h0;

  assign access_fault = none_ready;

  one_ready_a : assert property (@(posedge clk) disable iff (!resetn)
    $onehot0({ram_ready, uart_ready, timer_ready, freq_ready, none_ready}));

endmodule

// ==== source/soc_bus.sv ====
////////////////////////////////////////////////////////////
// top level of the peripheral fabric
// one master request at a time, answered after one cycle
// ram, uart tx, machine timer, frequency word, fault path
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module soc_bus (
  input  logic              clk,
  input  logic              resetn,
  input  logic              valid,
  input  soc_pkg::bus_req_t req,
  output soc_pkg::bus_rsp_t rsp,
  output logic              access_fault,
  output logic              uart_txd,
  output logic              timer_irq
);
  import soc_pkg::*;

  dev_sel_t    sel;
  logic [31:0] ram_rdata;
  logic [31:0] uart_rdata;
  logic [31:0] timer_rdata;
  logic        ram_ready;
  logic        uart_ready;
  logic        timer_ready;

  ////////////////////////////////////////////////////////////
  // decode, ready fed back to block the response cycle
  bus_decode u_decode (
    .clk     (clk),
    .resetn  (resetn),
    .valid   (valid),
    .req     (req),
    .pending (rsp.ready),
    .sel     (sel)
  );

  ////////////////////////////////////////////////////////////
  // devices
  block_ram u_ram (
    .clk    (clk),
    .resetn (resetn),
    .sel    (sel.ram),
    .req    (req),
    .rdata  (ram_rdata),
    .ready  (ram_ready)
  );

  uart_tx u_uart (
    .clk        (clk),
    .resetn     (resetn),
    .sel_data   (sel.uart_data),
    .sel_status (sel.uart_status),
    .req        (req),
    .rdata      (uart_rdata),
    .ready      (uart_ready),
    .txd        (uart_txd)
  );

  machine_timer u_timer (
    .clk    (clk),
    .resetn (resetn),
    .sel    (sel.timer),
    .req    (req),
    .rdata  (timer_rdata),
    .ready  (timer_ready),
    .irq    (timer_irq)
  );

  ////////////////////////////////////////////////////////////
  // response
  resp_mux u_resp (
    .clk          (clk),
    .resetn       (resetn),
    .sel          (sel),
    .ram_rdata    (ram_rdata),
    .uart_rdata   (uart_rdata),
    .timer_rdata  (timer_rdata),
    .ram_ready    (ram_ready),
    .uart_ready   (uart_ready),
    .timer_ready  (timer_ready),
    .rsp          (rsp),
    .access_fault (access_fault)
  );

endmodule

// ==== tests/tb_clock.sv ====
////////////////////////////////////////////////////////////
// clock and reset source for the testbench
// 100 ns clock period, resetn held low for three cycles
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_clock (
  output logic clk,
  output logic resetn
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // release just after the third rising edge
  initial begin
    resetn = 1'b0;
    repeat (3) @(posedge clk);
    #5;
    resetn = 1'b1;
  end

endmodule

// ==== tests/tb_soc.sv ====
////////////////////////////////////////////////////////////
// testbench for the peripheral fabric
// runs ram, uart, timer, frequency and fault accesses,
// predicts each response with a reference model and
// compares it in a separate process at the falling edge
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_soc;
  import soc_pkg::*;

  logic        clk;
  logic        resetn;
  logic        valid;
  bus_req_t    req;
  bus_rsp_t    rsp;
  logic        access_fault;
  logic        uart_txd;
  logic        timer_irq;

  int          errors;
  integer      seed;
  logic [31:0] ram_model [RAM_WORDS];

  // expectations, one entry per request in flight
  bus_rsp_t    exp_q [$];
  logic        fault_q [$];
  bit          exact_q [$];
  string       name_q [$];

  tb_clock u_clock (
    .clk    (clk),
    .resetn (resetn)
  );

  soc_bus i_dut (
    .clk          (clk),
    .resetn       (resetn),
    .valid        (valid),
    .req          (req),
    .rsp          (rsp),
    .access_fault (access_fault),
    .uart_txd     (uart_txd),
    .timer_irq    (timer_irq)
  );

  ////////////////////////////////////////////////////////////
  // compare tasks
  task automatic check_rsp(input string name, input bus_rsp_t exp, input bus_rsp_t act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic expect_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %b actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic match_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model: map decode, ram contents, faults
  // exact is low where the read value cannot be predicted
  function automatic bus_rsp_t predict_rsp(input bus_req_t r, output logic fault,
                                           output bit exact);
    bus_rsp_t e;
    int       w;
    int       b;
    e.ready = 1'b1;
    e.rdata = 32'h0;
    fault   = 1'b0;
    exact   = 1'b1;
    if (r.addr < RAM_END) begin
      w       = int'(r.addr[RAM_AW+1:2]);
      e.rdata = ram_model[w];
      for (b = 0; b < 4; b++) begin
        if (r.wstrb[b]) begin
          ram_model[w][8*b +: 8] = r.wdata[8*b +: 8];
        end
      end
      // a write returns the old word, not checked
      exact = (r.wstrb == 4'h0);
    end else if (r.addr == FREQ_ADDR) begin
      e.rdata = SYSTEM_CLK;
    end else if (r.addr == UART_TX_ADDR) begin
      e.rdata = 32'h0;
    end else if (r.addr == UART_LSR_ADDR) begin
      exact = 1'b0;
    end else if (r.addr[31:4] == TIMER_BASE[31:4] && r.addr[1:0] == 2'b00) begin
      exact = 1'b0;
    end else begin
      fault = 1'b1;
    end
    return e;
  endfunction

  function automatic bus_req_t build_req(input logic [31:0] addr, input logic [31:0] wdata,
                                         input logic [3:0] wstrb);
    bus_req_t r;
    r.addr  = addr;
    r.wdata = wdata;
    r.wstrb = wstrb;
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // one bus request, driven 5 ns after the rising edge
  task automatic bus_access(input string name, input bus_req_t r, output bus_rsp_t rs);
    bus_rsp_t e;
    logic     f;
    bit       ex;
    int       waited;
    e = predict_rsp(r, f, ex);
    exp_q.push_back(e);
    fault_q.push_back(f);
    exact_q.push_back(ex);
    name_q.push_back(name);
    @(posedge clk);
    #5;
    req    = r;
    valid  = 1'b1;
    waited = 0;
    do begin
      @(posedge clk);
      @(negedge clk);
      waited++;
    end while (!rsp.ready && waited < 20);
    rs = rsp;
    if (!rsp.ready) begin
      $display("timeout: no ready within 20 cycles for %s", name);
      errors++;
      void'(exp_q.pop_back());
      void'(fault_q.pop_back());
      void'(exact_q.pop_back());
      void'(name_q.pop_back());
    end else if (waited != 1) begin
      $display("%s: ready came %0d cycles after valid instead of 1", name, waited);
      errors++;
    end
    @(posedge clk);
    #5;
    valid = 1'b0;
  endtask

  // mid-bit sampler on the serial line
  task automatic sample_serial(output logic [7:0] data, output logic stop_bit);
    int waited;
    int i;
    data     = 8'h00;
    stop_bit = 1'b0;
    waited   = 0;
    while (uart_txd && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (uart_txd) begin
      $display("uart start bit not seen within 20 cycles");
      errors++;
    end else begin
      repeat (BAUD_DIV / 2) @(negedge clk);
      expect_flag("uart start bit", 1'b0, uart_txd);
      for (i = 0; i < 8; i++) begin
        repeat (BAUD_DIV) @(negedge clk);
        data[i] = uart_txd;
      end
      repeat (BAUD_DIV) @(negedge clk);
      stop_bit = uart_txd;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // response checker
  always @(negedge clk) begin : compare_responses
    bus_rsp_t e;
    logic     f;
    bit       ex;
    string    n;
    if (resetn && rsp.ready) begin
      if (exp_q.size() == 0) begin
        $display("ready pulse with no request outstanding");
        errors++;
      end else begin
        e  = exp_q.pop_front();
        f  = fault_q.pop_front();
        ex = exact_q.pop_front();
        n  = name_q.pop_front();
        if (ex) begin
          check_rsp(n, e, rsp);
        end
        expect_flag({n, " fault"}, f, access_fault);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  initial begin
    bus_rsp_t    rs;
    logic [31:0] addr_list [20];
    logic [31:0] rnd;
    logic [31:0] t1;
    logic [31:0] t2;
    logic [3:0]  strb;
    logic [7:0]  tx_byte;
    logic [7:0]  rx_byte;
    logic        stop_bit;
    bit          seen_busy;
    bit          seen_idle;
    int          n;
    errors = 0;
    seed   = 32'hb96f;
    valid  = 1'b0;
    req    = '0;

    n = 0;
    while (!resetn && n < 10) begin
      @(posedge clk);
      n++;
    end
    if (!resetn) begin
      $display("reset was never released");
      errors++;
    end
    @(negedge clk);
    expect_flag("ready after reset", 1'b0, rsp.ready);
    expect_flag("fault after reset", 1'b0, access_fault);
    expect_flag("irq after reset", 1'b0, timer_irq);
    expect_flag("txd after reset", 1'b1, uart_txd);

    // ram, random words with partial strobes
    for (int i = 0; i < 20; i++) begin
      rnd          = $random(seed);
      addr_list[i] = {rnd[RAM_AW-1:0], 2'b00};
      strb         = rnd[11:8];
      if (strb == 4'h0) begin
        strb = 4'hf;
      end
      bus_access("ram write", build_req(addr_list[i], $random(seed), strb), rs);
    end
    for (int i = 0; i < 20; i++) begin
      bus_access("ram read", build_req(addr_list[i], 32'h0, 4'h0), rs);
    end

    // uart frame and status polling
    rnd     = $random(seed);
    tx_byte = rnd[7:0];
    fork
      sample_serial(rx_byte, stop_bit);
      begin
        bus_access("uart data write", build_req(UART_TX_ADDR, {24'h0, tx_byte}, 4'h1), rs);
        seen_busy = 1'b0;
        seen_idle = 1'b0;
        n         = 0;
        while (!seen_idle && n < 60) begin
          bus_access("uart status", build_req(UART_LSR_ADDR, 32'h0, 4'h0), rs);
          n++;
          if (!rs.rdata[8+LSR_TX_EMPTY_BIT]) begin
            seen_busy = 1'b1;
          end else if (seen_busy) begin
            seen_idle = 1'b1;
          end
        end
        if (!seen_idle) begin
          $display("uart empty flag did not clear and return within 60 polls");
          errors++;
        end
      end
    join
    match_byte("uart byte", tx_byte, rx_byte);
    expect_flag("uart stop bit", 1'b1, stop_bit);

    // timer counting and interrupt
    bus_access("mtime low", build_req({TIMER_BASE[31:4], TIMER_MTIME_LO}, 32'h0, 4'h0), rs);
    t1 = rs.rdata;
    bus_access("mtime low", build_req({TIMER_BASE[31:4], TIMER_MTIME_LO}, 32'h0, 4'h0), rs);
    t2 = rs.rdata;
    expect_flag("mtime increments", 1'b1, t2 > t1);
    bus_access("mtimecmp high", build_req({TIMER_BASE[31:4], TIMER_CMP_HI}, 32'h0, 4'hf), rs);
    bus_access("mtime low", build_req({TIMER_BASE[31:4], TIMER_MTIME_LO}, 32'h0, 4'h0), rs);
    t1 = rs.rdata + 32'd30;
    bus_access("mtimecmp low", build_req({TIMER_BASE[31:4], TIMER_CMP_LO}, t1, 4'hf), rs);
    @(negedge clk);
    expect_flag("irq before compare", 1'b0, timer_irq);
    n = 0;
    while (!timer_irq && n < 60) begin
      @(negedge clk);
      n++;
    end
    if (!timer_irq) begin
      $display("timer interrupt did not rise within 60 cycles");
      errors++;
    end else begin
      repeat (10) begin
        @(negedge clk);
        expect_flag("irq held", 1'b1, timer_irq);
      end
    end

    // frequency word and unmapped accesses
    rnd = $random(seed);
    bus_access("ram fill", build_req(32'h0000_0040, rnd, 4'hf), rs);
    bus_access("freq read", build_req(FREQ_ADDR, 32'h0, 4'h0), rs);
    bus_access("unknown io read", build_req(32'h1000_0040, 32'h0, 4'h0), rs);
    bus_access("above io read", build_req(32'h1300_0040, 32'h0, 4'h0), rs);
    bus_access("unknown io write", build_req(32'h1000_0040, 32'hdead_beef, 4'hf), rs);
    bus_access("above io write", build_req(32'h1300_0040, 32'hdead_beef, 4'hf), rs);
    bus_access("ram after fault writes", build_req(32'h0000_0040, 32'h0, 4'h0), rs);

    repeat (2) @(negedge clk);
    if (exp_q.size() != 0) begin
      $display("%0d requests never received a response", exp_q.size());
      errors++;
    end
    $display("run complete, %0d errors", errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
source/soc_pkg.sv
source/bus_decode.sv
source/block_ram.sv
source/uart_tx.sv
source/machine_timer.sv
source/resp_mux.sv
source/soc_bus.sv
tests/tb_clock.sv
tests/tb_soc.sv

// ==== Bender.yml ====
package:
  name: soc_bus

sources:
  - source/soc_pkg.sv
  - source/bus_decode.sv
  - source/block_ram.sv
  - source/uart_tx.sv
  - source/machine_timer.sv
  - source/resp_mux.sv
  - source/soc_bus.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_soc.sv
